// ==== source/risc_isa_pkg.sv ====
package risc_isa_pkg;

   // Opcode field, instruction bits 15:9
   typedef enum logic [6:0] {
      OP_ADD  = 7'h70,
      OP_SUB  = 7'h71,
      OP_CMP  = 7'h72,
      OP_MOV  = 7'h73,
      OP_SHL  = 7'h74,
      OP_SHR  = 7'h75,
      OP_INC  = 7'h76,
      OP_DEC  = 7'h77,
      OP_LD   = 7'h78,
      OP_STO  = 7'h79,
      OP_LDI  = 7'h7A,
      OP_HALT = 7'h7B,
      OP_JE   = 7'h7C,
      OP_JNE  = 7'h7D,
      OP_JC   = 7'h7E,
      OP_JMP  = 7'h7F
   } opcode_t;

   typedef enum logic [3:0] {
      ALU_PASS = 4'b0000,
      ALU_INC  = 4'b0010,
      ALU_DEC  = 4'b0011,
      ALU_ADD  = 4'b0100,
      ALU_SUB  = 4'b0101,
      ALU_SHR  = 4'b0110,
      ALU_SHL  = 4'b0111
   } alu_op_t;

   // Opcode states carry their status code in the low bits
   typedef enum logic [4:0] {
      ST_ADD     = 5'd0,
      ST_SUB     = 5'd1,
      ST_CMP     = 5'd2,
      ST_MOV     = 5'd3,
      ST_SHL     = 5'd4,
      ST_SHR     = 5'd5,
      ST_INC     = 5'd6,
      ST_DEC     = 5'd7,
      ST_LD      = 5'd8,
      ST_STO     = 5'd9,
      ST_LDI     = 5'd10,
      ST_HALT    = 5'd11,
      ST_JE      = 5'd12,
      ST_JNE     = 5'd13,
      ST_JC      = 5'd14,
      ST_JMP     = 5'd15,
      ST_RESET   = 5'd16,
      ST_FETCH   = 5'd17,
      ST_DECODE  = 5'd18,
      ST_ILLEGAL = 5'd31
   } cu_state_t;

   typedef struct packed {
      logic n;   // Result bit 15
      logic z;   // Result is zero
      logic c;   // Carry, borrow or shifted-out bit
   } flags_t;

endpackage

// ==== source/risc_bus_pkg.sv ====
package risc_bus_pkg;

   localparam int WORD_W   = 16;
   localparam int ADDR_W   = 16;
   localparam int NUM_REGS = 8;

   // Register number width follows the register count
   localparam int REG_ADR_W = $clog2(NUM_REGS);

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic [REG_ADR_W-1:0] reg_adr_t;

endpackage

// ==== source/risc_control_unit.sv ====
`timescale 1ns/1ns

module risc_control_unit (
   input  logic                   clk,
   input  logic                   reset,
   input  risc_bus_pkg::word_t    ir,
   input  risc_isa_pkg::flags_t   alu_flags,
   input  logic                   mem_done,
   output risc_bus_pkg::reg_adr_t w_adr,
   output risc_bus_pkg::reg_adr_t r_adr,
   output risc_bus_pkg::reg_adr_t s_adr,
   output logic                   adr_sel,
   output logic                   s_sel,
   output logic                   pc_ld,
   output logic                   pc_inc,
   output logic                   pc_sel,
   output logic                   ir_ld,
   output logic                   rw_en,
   output logic                   mem_start,
   output logic                   mem_we,
   output risc_isa_pkg::alu_op_t  alu_op,
   output logic [7:0]             status
);

   import risc_isa_pkg::*;

   cu_state_t state;
   cu_state_t next_state;
   flags_t    flags;       // Present flags
   logic      flags_ld;    // Take ALU flags at end of state
   opcode_t   opcode;

   assign opcode = opcode_t'(ir[15:9]);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= ST_RESET;
         flags <= '0;
      end else begin
         state <= next_state;
         if (flags_ld)
            flags <= alu_flags;
      end
   end

   always_comb begin
      w_adr      = '0;
      r_adr      = '0;
      s_adr      = '0;
      adr_sel    = 1'b0;   // Bus address from PC
      s_sel      = 1'b0;   // Write-back from ALU
      pc_ld      = 1'b0;
      pc_inc     = 1'b0;
      pc_sel     = 1'b0;
      ir_ld      = 1'b0;
      rw_en      = 1'b0;
      mem_start  = 1'b0;
      mem_we     = 1'b0;
      alu_op     = ALU_PASS;
      flags_ld   = 1'b0;
      status     = {flags, state};
      next_state = ST_FETCH;

      case (state)
         ST_RESET: status = 8'hFF;

         ST_FETCH: begin
            // IR <- M[PC] and PC <- PC + 1 once the read completes
            status    = 8'h80;
            mem_start = 1'b1;
            ir_ld     = mem_done;
            pc_inc    = mem_done;
            if (mem_done)
               next_state = ST_DECODE;
            else
               next_state = ST_FETCH;
         end

         ST_DECODE: begin
            status = 8'hC0;
            case (opcode)
               OP_ADD:  next_state = ST_ADD;
               OP_SUB:  next_state = ST_SUB;
               OP_CMP:  next_state = ST_CMP;
               OP_MOV:  next_state = ST_MOV;
               OP_SHL:  next_state = ST_SHL;
               OP_SHR:  next_state = ST_SHR;
               OP_INC:  next_state = ST_INC;
               OP_DEC:  next_state = ST_DEC;
               OP_LD:   next_state = ST_LD;
               OP_STO:  next_state = ST_STO;
               OP_LDI:  next_state = ST_LDI;
               OP_HALT: next_state = ST_HALT;
               OP_JE:   next_state = ST_JE;
               OP_JNE:  next_state = ST_JNE;
               OP_JC:   next_state = ST_JC;
               OP_JMP:  next_state = ST_JMP;
               default: next_state = ST_ILLEGAL;
            endcase
         end

         ST_ADD, ST_SUB, ST_CMP: begin
            // R[ir8:6] <- R[ir5:3] op R[ir2:0]
            w_adr    = ir[8:6];
            r_adr    = ir[5:3];
            s_adr    = ir[2:0];
            alu_op   = (state == ST_ADD) ? ALU_ADD : ALU_SUB;
            rw_en    = (state != ST_CMP);   // CMP only sets flags
            flags_ld = 1'b1;
         end

         ST_MOV, ST_SHL, ST_SHR, ST_INC, ST_DEC: begin
            // R[ir8:6] <- op R[ir2:0]
            w_adr    = ir[8:6];
            s_adr    = ir[2:0];
            rw_en    = 1'b1;
            flags_ld = (state != ST_MOV);
            case (state)
               ST_SHL:  alu_op = ALU_SHL;
               ST_SHR:  alu_op = ALU_SHR;
               ST_INC:  alu_op = ALU_INC;
               ST_DEC:  alu_op = ALU_DEC;
               default: alu_op = ALU_PASS;
            endcase
         end

         ST_LD: begin
            w_adr     = ir[8:6];
            r_adr     = ir[2:0];   // Address register
            adr_sel   = 1'b1;
            s_sel     = 1'b1;
            mem_start = 1'b1;
            rw_en     = mem_done;
            if (!mem_done)
               next_state = ST_LD;
         end

         ST_STO: begin
            // M[R[ir8:6]] <- R[ir2:0]
            r_adr     = ir[8:6];
            s_adr     = ir[2:0];
            adr_sel   = 1'b1;
            mem_start = 1'b1;
            mem_we    = 1'b1;
            if (!mem_done)
               next_state = ST_STO;
         end

         ST_LDI: begin
            // Immediate word follows the instruction
            w_adr     = ir[8:6];
            s_sel     = 1'b1;
            mem_start = 1'b1;
            rw_en     = mem_done;
            pc_inc    = mem_done;
            if (!mem_done)
               next_state = ST_LDI;
         end

         ST_JE:  pc_ld = flags.z;
         ST_JNE: pc_ld = !flags.z;
         ST_JC:  pc_ld = flags.c;

         ST_JMP: begin
            s_adr  = ir[2:0];      // Absolute target register
            pc_sel = 1'b1;
            pc_ld  = 1'b1;
         end

         ST_HALT: next_state = ST_HALT;

         default: begin
            status     = 8'hF0;   // Illegal opcode, stays here
            next_state = ST_ILLEGAL;
         end
      endcase
   end

endmodule

// ==== source/risc_execution_unit.sv ====
`timescale 1ns/1ns

module risc_execution_unit #(
   parameter risc_bus_pkg::addr_t reset_pc = '0
) (
   input  logic                   clk,
   input  logic                   reset,
   input  risc_bus_pkg::reg_adr_t w_adr,
   input  risc_bus_pkg::reg_adr_t r_adr,
   input  risc_bus_pkg::reg_adr_t s_adr,
   input  logic                   adr_sel,
   input  logic                   s_sel,
   input  logic                   pc_ld,
   input  logic                   pc_inc,
   input  logic                   pc_sel,
   input  logic                   ir_ld,
   input  logic                   rw_en,
   input  risc_isa_pkg::alu_op_t  alu_op,
   input  risc_bus_pkg::word_t    rdata,
   output risc_bus_pkg::word_t    ir,
   output risc_isa_pkg::flags_t   alu_flags,
   output risc_bus_pkg::addr_t    bus_adr,
   output risc_bus_pkg::word_t    bus_wdata
);

   import risc_isa_pkg::*;
   import risc_bus_pkg::*;

   word_t regs [NUM_REGS];
   addr_t pc;
   word_t r_data;          // R[r_adr]
   word_t s_data;          // R[s_adr]
   word_t alu_y;
   logic  alu_c;
   word_t wb_data;
   addr_t pc_target;

   assign r_data = regs[r_adr];
   assign s_data = regs[s_adr];

   // Single-operand ops act on R[s_adr]
   always_comb begin
      alu_c = 1'b0;
      case (alu_op)
         ALU_INC: {alu_c, alu_y} = {1'b0, s_data} + 17'd1;
         ALU_DEC: {alu_c, alu_y} = {1'b0, s_data} - 17'd1;   // Borrow at zero
         ALU_ADD: {alu_c, alu_y} = {1'b0, r_data} + {1'b0, s_data};
         ALU_SUB: {alu_c, alu_y} = {1'b0, r_data} - {1'b0, s_data};
         ALU_SHR: {alu_y, alu_c} = {1'b0, s_data};   // Bit 0 out to carry
         ALU_SHL: {alu_c, alu_y} = {s_data, 1'b0};   // Bit 15 out to carry
         default: alu_y = s_data;                    // MOV
      endcase
   end

   assign alu_flags = {alu_y[15], ~|alu_y, alu_c};

   assign wb_data = s_sel ? rdata : alu_y;

   always_ff @(posedge clk) begin
      if (rw_en)
         regs[w_adr] <= wb_data;
      if (ir_ld)
         ir <= rdata;
   end

   // Relative branch from the already incremented PC, or JMP register
   assign pc_target = pc_sel ? s_data : pc + {{8{ir[7]}}, ir[7:0]};

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         pc <= reset_pc;
      else if (pc_ld)
         pc <= pc_target;
      else if (pc_inc)
         pc <= pc + 16'd1;
   end

   assign bus_adr   = adr_sel ? r_data : pc;
   assign bus_wdata = s_data;   // Store data

endmodule

// ==== source/risc_bus_port.sv ====
`timescale 1ns/1ns

module risc_bus_port (
   input  logic                clk,
   input  logic                reset,
   input  logic                mem_start,
   input  logic                mem_we,
   input  risc_bus_pkg::addr_t bus_adr,
   input  risc_bus_pkg::word_t bus_wdata,
   output logic                mem_done,
   output risc_bus_pkg::word_t rdata,
   output logic                mem_req,
   output logic                mem_wr,
   output risc_bus_pkg::addr_t mem_adr,
   output risc_bus_pkg::word_t mem_wdata,
   input  risc_bus_pkg::word_t mem_rdata,
   input  logic                mem_ack
);

   typedef enum logic [1:0] {
      IDLE,
      WAIT_ACK_HI,
      WAIT_ACK_LO
   } port_state_t;

   port_state_t state;
   logic        launch;    // New transfer this cycle
   logic        capture;   // First cycle ack seen

   // Skip the done cycle so a held start does not retrigger
   assign launch  = (state == IDLE) && mem_start && !mem_done && !mem_ack;
   assign capture = (state == WAIT_ACK_HI) && mem_ack;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state    <= IDLE;
         mem_req  <= 1'b0;
         mem_wr   <= 1'b0;
         mem_done <= 1'b0;
      end else begin
         mem_done <= 1'b0;
         case (state)
            IDLE: begin
               if (launch) begin
                  mem_req <= 1'b1;
                  mem_wr  <= mem_we;
                  state   <= WAIT_ACK_HI;
               end
            end
            WAIT_ACK_HI: begin
               if (capture) begin
                  mem_req <= 1'b0;
                  state   <= WAIT_ACK_LO;
               end
            end
            WAIT_ACK_LO: begin
               if (!mem_ack) begin
                  mem_done <= 1'b1;   // One-cycle pulse
                  state    <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (launch) begin
         mem_adr   <= bus_adr;
         mem_wdata <= bus_wdata;
      end
      if (capture)
         rdata <= mem_rdata;
   end

endmodule

// ==== source/risc_cpu.sv ====
`timescale 1ns/1ns

module risc_cpu #(
   parameter risc_bus_pkg::addr_t reset_pc = '0   // First fetch address
) (
   input  logic                clk,
   input  logic                reset,
   output logic                mem_req,
   output logic                mem_wr,
   output risc_bus_pkg::addr_t mem_adr,
   output risc_bus_pkg::word_t mem_wdata,
   input  risc_bus_pkg::word_t mem_rdata,
   input  logic                mem_ack,
   output logic [7:0]          status
);

   import risc_isa_pkg::*;
   import risc_bus_pkg::*;

   reg_adr_t w_adr;
   reg_adr_t r_adr;
   reg_adr_t s_adr;
   logic     adr_sel;
   logic     s_sel;
   logic     pc_ld;
   logic     pc_inc;
   logic     pc_sel;
   logic     ir_ld;
   logic     rw_en;
   alu_op_t  alu_op;
   word_t    ir;
   flags_t   alu_flags;
   logic     mem_start;
   logic     mem_we;
   logic     mem_done;
   addr_t    bus_adr;
   word_t    bus_wdata;
   word_t    rdata;

   risc_control_unit u_cu (
      .clk       (clk),
      .reset     (reset),
      .ir        (ir),
      .alu_flags (alu_flags),
      .mem_done  (mem_done),
      .w_adr     (w_adr),
      .r_adr     (r_adr),
      .s_adr     (s_adr),
      .adr_sel   (adr_sel),
      .s_sel     (s_sel),
      .pc_ld     (pc_ld),
      .pc_inc    (pc_inc),
      .pc_sel    (pc_sel),
      .ir_ld     (ir_ld),
      .rw_en     (rw_en),
      .mem_start (mem_start),
      .mem_we    (mem_we),
      .alu_op    (alu_op),
      .status    (status)
   );

   risc_execution_unit #(
      .reset_pc (reset_pc)
   ) u_eu (
      .clk       (clk),
      .reset     (reset),
      .w_adr     (w_adr),
      .r_adr     (r_adr),
      .s_adr     (s_adr),
      .adr_sel   (adr_sel),
      .s_sel     (s_sel),
      .pc_ld     (pc_ld),
      .pc_inc    (pc_inc),
      .pc_sel    (pc_sel),
      .ir_ld     (ir_ld),
      .rw_en     (rw_en),
      .alu_op    (alu_op),
      .rdata     (rdata),
      .ir        (ir),
      .alu_flags (alu_flags),
      .bus_adr   (bus_adr),
      .bus_wdata (bus_wdata)
   );

   risc_bus_port u_port (
      .clk       (clk),
      .reset     (reset),
      .mem_start (mem_start),
      .mem_we    (mem_we),
      .bus_adr   (bus_adr),
      .bus_wdata (bus_wdata),
      .mem_done  (mem_done),
      .rdata     (rdata),
      .mem_req   (mem_req),
      .mem_wr    (mem_wr),
      .mem_adr   (mem_adr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata),
      .mem_ack   (mem_ack)
   );

endmodule

// ==== dv/risc_cpu_chk.sv ====
`timescale 1ns/1ns

module risc_cpu_chk (
   input logic                clk,
   input logic                reset,
   input logic                mem_req,
   input logic                mem_wr,
   input risc_bus_pkg::addr_t mem_adr,
   input logic                mem_ack
);

   int fail_count;   // Assertion failures so far

   initial fail_count = 0;

   // Master side of the four-phase handshake
   req_held: assert property (@(posedge clk) disable iff (reset)
      mem_req && !mem_ack |=> mem_req)
      else begin
         fail_count++;
         $error("mem_req dropped before mem_ack was seen");
      end

   no_req_during_ack: assert property (@(posedge clk) disable iff (reset)
      !mem_req && mem_ack |=> !mem_req)
      else begin
         fail_count++;
         $error("mem_req rose while mem_ack was high");
      end

   // Address and direction frozen for the whole request
   request_stable: assert property (@(posedge clk) disable iff (reset)
      mem_req |=> !mem_req || ($stable(mem_adr) && $stable(mem_wr)))
      else begin
         fail_count++;
         $error("mem_adr or mem_wr changed while mem_req was high");
      end

   req_low_after_reset: assert property (@(posedge clk)
      reset |=> !mem_req)
      else begin
         fail_count++;
         $error("mem_req high in the cycle after reset");
      end

endmodule

bind risc_cpu risc_cpu_chk risc_cpu_chk_i (
   .clk     (clk),
   .reset   (reset),
   .mem_req (mem_req),
   .mem_wr  (mem_wr),
   .mem_adr (mem_adr),
   .mem_ack (mem_ack)
);

// ==== dv/risc_cpu_tb.sv ====
`timescale 1ns/1ns

module risc_cpu_tb;

   import risc_isa_pkg::*;
   import risc_bus_pkg::*;

   localparam int           CLK_PERIOD  = 20;
   localparam int           MAX_CYCLES  = 350;     // Per program run
   localparam addr_t        RESET_PC    = 16'h0000;
   localparam logic [4:0]   HALT_CODE   = 5'b01011;
   localparam logic [7:0]   RESULT_ADR  = 8'h80;
   localparam word_t        PRIOR_R3    = 16'h5A5A;
   localparam word_t        TAKEN_MARK  = 16'h7777;
   localparam word_t        NOT_TAKEN   = 16'h1111;

   // Program shape for each table entry
   typedef enum {K_ALU, K_LD, K_JMP, K_BR_BACK, K_BR_FWD, K_ILL, K_RST} kind_t;

   logic       clk;
   logic       reset;
   logic       mem_req;
   logic       mem_wr;
   addr_t      mem_adr;
   word_t      mem_wdata;
   word_t      mem_rdata;
   logic       mem_ack;
   logic [7:0] status;

   word_t   mem [256];
   int      wp;              // Program write pointer
   int      wr_count;        // Bus writes seen by the memory
   int      errors;
   int      failed_tests;
   string   t_name [$];
   opcode_t t_op [$];
   word_t   t_a [$];
   word_t   t_b [$];
   kind_t   t_kind [$];

   risc_cpu #(
      .reset_pc (RESET_PC)
   ) risc_cpu_i (
      .clk       (clk),
      .reset     (reset),
      .mem_req   (mem_req),
      .mem_wr    (mem_wr),
      .mem_adr   (mem_adr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata),
      .mem_ack   (mem_ack),
      .status    (status)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // Four-phase memory, samples at negedge and answers 2 ns after posedge
   initial begin
      int    delay;
      logic  busy;
      logic  rst_s;
      logic  req_s;
      logic  wr_s;
      addr_t adr_s;
      word_t wdata_s;
      void'($urandom(32'h3e5a));
      mem_ack   = 1'b0;
      mem_rdata = '0;
      busy      = 1'b0;
      delay     = 0;
      forever begin
         @(negedge clk);
         rst_s   = reset;
         req_s   = mem_req;
         wr_s    = mem_wr;
         adr_s   = mem_adr;
         wdata_s = mem_wdata;
         @(posedge clk);
         #2;
         if (rst_s) begin
            mem_ack = 1'b0;
            busy    = 1'b0;
         end else if (req_s && !mem_ack) begin
            if (!busy) begin
               busy  = 1'b1;
               delay = $urandom % 4;   // 0 to 3 wait cycles
            end
            if (delay == 0) begin
               if (wr_s) begin
                  mem[adr_s[7:0]] = wdata_s;
                  wr_count++;
               end else begin
                  mem_rdata = mem[adr_s[7:0]];
               end
               mem_ack = 1'b1;
               busy    = 1'b0;
            end else begin
               delay--;
            end
         end else if (!req_s && mem_ack) begin
            mem_ack = 1'b0;
         end
      end
   end

   task automatic add_test(input string name, input opcode_t op, input word_t a,
                           input word_t b, input kind_t kind);
      t_name.push_back(name);
      t_op.push_back(op);
      t_a.push_back(a);
      t_b.push_back(b);
      t_kind.push_back(kind);
   endtask

   task automatic build_table();
      add_test("add_carry",    OP_ADD, 16'hFFFF, 16'h0001, K_ALU);
      add_test("add_plain",    OP_ADD, 16'h1234, 16'h0F0F, K_ALU);
      add_test("add_negative", OP_ADD, 16'h7FFF, 16'h0001, K_ALU);
      add_test("sub_borrow",   OP_SUB, 16'h0000, 16'h0001, K_ALU);
      add_test("sub_zero",     OP_SUB, 16'h5555, 16'h5555, K_ALU);
      add_test("cmp_less",     OP_CMP, 16'h0003, 16'h0009, K_ALU);
      add_test("cmp_equal",    OP_CMP, 16'h8000, 16'h8000, K_ALU);
      add_test("inc_wrap",     OP_INC, 16'hFFFF, 16'h0000, K_ALU);
      add_test("dec_wrap",     OP_DEC, 16'h0000, 16'h0000, K_ALU);
      add_test("shl_top",      OP_SHL, 16'h8001, 16'h0000, K_ALU);
      add_test("shr_low",      OP_SHR, 16'h0003, 16'h0000, K_ALU);
      add_test("shr_top",      OP_SHR, 16'h8000, 16'h0000, K_ALU);
      add_test("mov_keeps",    OP_MOV, 16'hA5C3, 16'h0000, K_ALU);
      add_test("ld_indirect",  OP_LD,  16'h00A0, 16'hBEEF, K_LD);
      add_test("jmp_register", OP_JMP, 16'h600D, 16'hBAD0, K_JMP);
      add_test("je_cmp_taken", OP_JE,  16'h0042, 16'h0042, K_BR_BACK);
      add_test("je_cmp_not",   OP_JE,  16'h0042, 16'h0041, K_BR_BACK);
      add_test("jne_cmp",      OP_JNE, 16'h0010, 16'h0020, K_BR_BACK);
      add_test("jc_cmp",       OP_JC,  16'h0001, 16'h0002, K_BR_BACK);
      add_test("jc_add_taken", OP_JC,  16'hFFF0, 16'h0020, K_BR_FWD);
      add_test("jc_add_not",   OP_JC,  16'h0001, 16'h0002, K_BR_FWD);
      add_test("je_add",       OP_JE,  16'hFFFF, 16'h0001, K_BR_FWD);
      add_test("jne_add_not",  OP_JNE, 16'h0000, 16'h0000, K_BR_FWD);
      add_test("illegal_op",   opcode_t'(7'h00), 16'h0000, 16'h0000, K_ILL);
      add_test("reset_mid",    OP_ADD, 16'h1234, 16'h4321, K_RST);
   endtask

   function automatic word_t enc(input opcode_t op, input reg_adr_t w, input reg_adr_t r,
                                 input reg_adr_t s);
      return {op, w, r, s};
   endfunction

   task automatic put(input word_t w);
      mem[wp] = w;
      wp++;
   endtask

   task automatic put_ldi(input reg_adr_t w, input word_t value);
      put(enc(OP_LDI, w, 3'd0, 3'd0));
      put(value);
   endtask

   task automatic load_program(input kind_t kind, input opcode_t op, input word_t a,
                               input word_t b);
      for (int i = 0; i < 256; i++)
         mem[i] = word_t'(i);   // Fill decodes as illegal
      wp = 0;
      case (kind)
         K_ALU, K_RST: begin
            put_ldi(3'd1, a);
            put_ldi(3'd2, b);
            put_ldi(3'd3, PRIOR_R3);
            put(enc(OP_CMP, 3'd5, 3'd1, 3'd1));   // Z set so MOV and LDI show kept flags
            if (op == OP_ADD || op == OP_SUB || op == OP_CMP)
               put(enc(op, 3'd3, 3'd1, 3'd2));
            else
               put(enc(op, 3'd3, 3'd0, 3'd1));
            put_ldi(3'd4, word_t'(RESULT_ADR));
            put(enc(OP_STO, 3'd4, 3'd0, 3'd3));
            put(enc(OP_HALT, 3'd0, 3'd0, 3'd0));
         end
         K_LD: begin
            mem[a[7:0]] = b;
            put_ldi(3'd1, a);
            put(enc(OP_CMP, 3'd5, 3'd1, 3'd1));
            put(enc(OP_LD, 3'd3, 3'd0, 3'd1));
            put_ldi(3'd4, word_t'(RESULT_ADR));
            put(enc(OP_STO, 3'd4, 3'd0, 3'd3));
            put(enc(OP_HALT, 3'd0, 3'd0, 3'd0));
         end
         K_JMP: begin
            put_ldi(3'd4, word_t'(RESULT_ADR));
            put_ldi(3'd2, b);
            put_ldi(3'd3, a);
            put_ldi(3'd7, 16'd11);                 // Word 11, the HALT
            put(enc(OP_STO, 3'd4, 3'd0, 3'd3));
            put(enc(OP_JMP, 3'd0, 3'd0, 3'd7));
            put(enc(OP_STO, 3'd4, 3'd0, 3'd2));   // Wrong marker, skipped
            put(enc(OP_HALT, 3'd0, 3'd0, 3'd0));
         end
         K_BR_BACK, K_BR_FWD: begin
            put_ldi(3'd1, a);
            put_ldi(3'd2, b);
            put_ldi(3'd4, word_t'(RESULT_ADR));
            put_ldi(3'd5, TAKEN_MARK);
            put_ldi(3'd6, NOT_TAKEN);
            put_ldi(3'd7, 16'd15);
            put(enc(OP_JMP, 3'd0, 3'd0, 3'd7));    // Over the backward target
            put(enc(OP_STO, 3'd4, 3'd0, 3'd5));    // Word 13, backward target
            put(enc(OP_HALT, 3'd0, 3'd0, 3'd0));
            if (kind == K_BR_BACK)
               put(enc(OP_CMP, 3'd3, 3'd1, 3'd2));
            else
               put(enc(OP_ADD, 3'd3, 3'd1, 3'd2));
            // PC already at 17 when the offset is added
            put({op, 1'b0, (kind == K_BR_BACK) ? 8'hFC : 8'h02});
            put(enc(OP_STO, 3'd4, 3'd0, 3'd6));
            put(enc(OP_HALT, 3'd0, 3'd0, 3'd0));
            put(enc(OP_STO, 3'd4, 3'd0, 3'd5));    // Word 19, forward target
            put(enc(OP_HALT, 3'd0, 3'd0, 3'd0));
         end
         default: begin
            put_ldi(3'd4, word_t'(RESULT_ADR));
            put({op, 9'h000});
            put(enc(OP_STO, 3'd4, 3'd0, 3'd4));
            put(enc(OP_HALT, 3'd0, 3'd0, 3'd0));
         end
      endcase
   endtask

   // Reference model of the ALU and flag rules
   function automatic word_t alu_ref(input opcode_t op, input word_t a, input word_t b,
                                     output flags_t f);
      word_t y;
      logic  c;
      int    sum;
      y = a;
      c = 1'b0;
      case (op)
         OP_ADD: begin
            sum = int'(a) + int'(b);
            y   = word_t'(sum);
            c   = (sum > 65535);
         end
         OP_SUB, OP_CMP: begin
            y = a - b;
            c = (a < b);   // Unsigned borrow
         end
         OP_INC: begin
            y = a + 16'd1;
            c = (a == 16'hFFFF);
         end
         OP_DEC: begin
            y = a - 16'd1;
            c = (a == 16'h0000);
         end
         OP_SHL: begin
            y = a << 1;
            c = a[15];
         end
         OP_SHR: begin
            y = a >> 1;
            c = a[0];
         end
         default: y = a;
      endcase
      f = {y[15], (y == 16'h0000), c};
      return y;
   endfunction

   // Check errors plus protocol assertion failures
   function automatic int error_total();
      return errors + risc_cpu_i.risc_cpu_chk_i.fail_count;
   endfunction

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("[FAIL] %s: expected word %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_flags(input string name, input flags_t exp, input flags_t act);
      if (act !== exp) begin
         $display("[FAIL] %s: expected flags NZC %b, actual %b", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_status(input string name, input logic [7:0] exp,
                               input logic [7:0] act);
      if (act !== exp) begin
         $display("[FAIL] %s: expected status %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic apply_reset(input string name);
      logic bad;
      bad = 1'b0;
      @(posedge clk);
      #2;
      reset = 1'b1;
      repeat (3) begin
         @(negedge clk);
         if (status !== 8'hFF)
            bad = 1'b1;
      end
      @(posedge clk);
      #2;
      reset = 1'b0;
      if (bad) begin
         $display("%s: status did not read FF while reset was held", name);
         errors++;
      end
   endtask

   // Runs until HALT or the illegal state shows on status
   task automatic wait_end(input string name);
      int   cycles;
      logic done;
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < MAX_CYCLES) begin
         @(negedge clk);
         cycles++;
         done = (status[4:0] == HALT_CODE) || (status == 8'hF0);
      end
      if (!done) begin
         $display("%s: program did not stop within %0d cycles", name, MAX_CYCLES);
         errors++;
      end
   endtask

   task automatic run_test(input int t);
      word_t  exp_w;
      flags_t exp_f;
      logic   taken;
      int     errs_at_start;
      errs_at_start = error_total();
      wr_count      = 0;
      exp_w         = '0;
      exp_f         = '0;
      load_program(t_kind[t], t_op[t], t_a[t], t_b[t]);
      apply_reset(t_name[t]);
      if (t_kind[t] == K_RST) begin
         repeat (12) @(posedge clk);
         apply_reset(t_name[t]);   // Restart mid-program
      end
      wait_end(t_name[t]);
      case (t_kind[t])
         K_ALU, K_RST: begin
            exp_w = alu_ref(t_op[t], t_a[t], t_b[t], exp_f);
            if (t_op[t] == OP_CMP)
               exp_w = PRIOR_R3;
            if (t_op[t] == OP_MOV)
               exp_f = 3'b010;   // From the earlier CMP
         end
         K_LD: begin
            exp_w = t_b[t];
            exp_f = 3'b010;
         end
         K_JMP: exp_w = t_a[t];
         K_BR_BACK, K_BR_FWD: begin
            void'(alu_ref((t_kind[t] == K_BR_BACK) ? OP_CMP : OP_ADD, t_a[t], t_b[t],
                          exp_f));
            case (t_op[t])
               OP_JE:   taken = exp_f.z;
               OP_JNE:  taken = !exp_f.z;
               default: taken = exp_f.c;
            endcase
            exp_w = taken ? TAKEN_MARK : NOT_TAKEN;
         end
         default: ;
      endcase
      if (t_kind[t] == K_ILL) begin
         repeat (20) @(negedge clk);
         check_status(t_name[t], 8'hF0, status);
         if (wr_count != 0 || mem_req !== 1'b0) begin
            $display("%s: bus activity seen after the illegal opcode", t_name[t]);
            errors++;
         end
      end else if (status[4:0] != HALT_CODE) begin
         $display("%s: program did not end in HALT, status %h", t_name[t], status);
         errors++;
      end else begin
         check_word(t_name[t], exp_w, mem[RESULT_ADR]);
         check_flags(t_name[t], exp_f, flags_t'(status[7:5]));
      end
      if (error_total() == errs_at_start) begin
         $display("%s: ok", t_name[t]);
      end else begin
         $display("%s: failed", t_name[t]);
         failed_tests++;
      end
   endtask

   initial begin
      reset        = 1'b1;
      wr_count     = 0;
      errors       = 0;
      failed_tests = 0;
      build_table();
      for (int t = 0; t < t_name.size(); t++)
         run_test(t);
      $display("tests run %0d, tests failed %0d, check errors %0d",
               t_name.size(), failed_tests, error_total());
      if (failed_tests == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // Limit scales with the table length
   initial begin
      #1;
      #(t_name.size() * 400 * CLK_PERIOD);
      $display("Watchdog expired before the test table finished");
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== sim.f ====
source/risc_isa_pkg.sv
source/risc_bus_pkg.sv
source/risc_control_unit.sv
source/risc_execution_unit.sv
source/risc_bus_port.sv
source/risc_cpu.sv
dv/risc_cpu_chk.sv
dv/risc_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: risc_cpu

sources:
  - files:
      - source/risc_isa_pkg.sv
      - source/risc_bus_pkg.sv
      - source/risc_control_unit.sv
      - source/risc_execution_unit.sv
      - source/risc_bus_port.sv
      - source/risc_cpu.sv
  - target: test
    files:
      - dv/risc_cpu_chk.sv
      - dv/risc_cpu_tb.sv
